//--- hdl/tcp_rx_config.svh
`ifndef TCP_RX_CONFIG_SVH
`define TCP_RX_CONFIG_SVH

// fixed part of the tcp header, in bytes
`define TCP_HDR_LEN 20

// ipv4 protocol number carried by tcp frames
`define TCP_PROTO 8'd6

// offset field is 4 bits of 32-bit words, so at most 60 - 20 bytes of options
`define TCP_MAX_OPT_LEN 40

`endif

//--- hdl/net_stream_pkg.sv
`default_nettype none

package net_stream_pkg;

  // one byte of a frame with its framing flags
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
    logic       sof;
    logic       eof;
  } byte_strm_t;

  // ipv4 addresses
  typedef logic [31:0] ipv4_addr_t;

  // metadata from the ipv4 layer, valid together with the first byte
  typedef struct packed {
    ipv4_addr_t  src_ip;
    ipv4_addr_t  dst_ip;
    logic [7:0]  proto;
    // bytes after the ipv4 header, tcp header included
    logic [15:0] pld_len;
  } ipv4_meta_t;

endpackage

`default_nettype wire

//--- hdl/tcp_hdr_pkg.sv
`default_nettype none

package tcp_hdr_pkg;

  // fixed header, first byte on the wire sits in the top bits
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq;
    logic [31:0] ack;
    logic [3:0]  offset;
    // reserved bits in the upper part, cwr..fin in the low 8 bits
    logic [11:0] flags;
    logic [15:0] window;
    logic [15:0] checksum;
    logic [15:0] urg_ptr;
  } tcp_hdr_t;

  typedef enum logic [7:0] {
    opt_end       = 8'd0,
    opt_nop       = 8'd1,
    opt_mss       = 8'd2,
    opt_win       = 8'd3,
    opt_sack_perm = 8'd4,
    opt_sack      = 8'd5,
    opt_ts        = 8'd8
  } tcp_opt_kind_t;

  // decoded option area
  typedef struct packed {
    logic        mss_pres;
    logic [15:0] mss;
    logic        win_pres;
    logic [7:0]  win_scale;
    logic        sack_perm;
    logic        sack_pres;
    // number of sack blocks, 0 when the length was not a valid one
    logic [2:0]  sack_blocks;
    logic        ts_pres;
    logic [31:0] ts_val;
    logic [31:0] ts_echo;
  } tcp_opt_t;

  typedef struct packed {
    logic                      val;
    net_stream_pkg::ipv4_meta_t ipv4;
    tcp_hdr_t                  hdr;
    tcp_opt_t                  opt;
    logic [15:0]               pld_len;
  } tcp_meta_t;

endpackage

`default_nettype wire

//--- hdl/tcp_hdr_decode.sv
`default_nettype none
`timescale 1ns/1ps
`include "tcp_rx_config.svh"

module tcp_hdr_decode (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  net_stream_pkg::byte_strm_t in_strm,
  input  net_stream_pkg::ipv4_meta_t in_meta,
  output net_stream_pkg::byte_strm_t byte_bus,
  output logic                       opt_act,
  output logic                       pld_act,
  output logic                       pld_first,
  output logic                       pld_last,
  output logic                       frame_done,
  output tcp_hdr_pkg::tcp_hdr_t      hdr,
  output net_stream_pkg::ipv4_meta_t ip_meta,
  output logic [15:0]                pld_len
);

  import tcp_hdr_pkg::*;

  localparam int HDR_CNT_W = $clog2(`TCP_HDR_LEN + 1);
  localparam int OPT_CNT_W = $clog2(`TCP_MAX_OPT_LEN + 1);
  // byte 12 carries the data offset in its top nibble
  localparam int OFFSET_POS = 12;

  typedef enum logic [2:0] {ph_idle, ph_hdr, ph_opt, ph_pld, ph_done, ph_skip} phase_t;

  phase_t                     phase;
  logic [HDR_CNT_W-1:0]       hdr_cnt;
  logic [OPT_CNT_W-1:0]       opt_cnt;
  logic [OPT_CNT_W-1:0]       opt_len;
  logic [15:0]                pld_cnt;
  logic [5:0]                 off_bytes;
  logic [`TCP_HDR_LEN-2:0][7:0] hdr_win;
  logic                       tcp_sof;

  // bytes go on to the other blocks untouched, the strobes mark what they are
  assign byte_bus   = in_strm;
  assign tcp_sof    = in_strm.val && in_strm.sof && (in_meta.proto == `TCP_PROTO);
  assign opt_act    = (phase == ph_opt) && in_strm.val;
  assign pld_act    = (phase == ph_pld) && in_strm.val;
  assign pld_first  = pld_act && (pld_cnt == 16'd0);
  assign pld_last   = pld_act && (pld_cnt == pld_len - 16'd1);
  assign frame_done = (phase == ph_done);

  // last 19 bytes seen, the 20th is taken straight from the input
  always_ff @(posedge clk) begin
    if (in_strm.val) begin
      hdr_win <= {hdr_win[`TCP_HDR_LEN-3:0], in_strm.dat};
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      phase   <= ph_idle;
      hdr_cnt <= '0;
      opt_cnt <= '0;
      pld_cnt <= '0;
    end else begin
      case (phase)
        ph_idle: begin
          if (tcp_sof) begin
            ip_meta <= in_meta;
            hdr_cnt <= HDR_CNT_W'(1);
            phase   <= ph_hdr;
          end else if (in_strm.val && in_strm.sof && !in_strm.eof) begin
            // some other protocol, wait for its end
            phase <= ph_skip;
          end
        end
        ph_hdr: begin
          if (in_strm.val) begin
            hdr_cnt <= hdr_cnt + HDR_CNT_W'(1);
            if (hdr_cnt == HDR_CNT_W'(OFFSET_POS)) begin
              off_bytes <= {in_strm.dat[7:4], 2'b00};
              pld_len   <= ip_meta.pld_len - {10'd0, in_strm.dat[7:4], 2'b00};
            end
            if (hdr_cnt == HDR_CNT_W'(`TCP_HDR_LEN - 1)) begin
              hdr     <= tcp_hdr_t'({hdr_win, in_strm.dat});
              hdr_cnt <= '0;
              opt_cnt <= '0;
              pld_cnt <= '0;
              if (off_bytes > 6'(`TCP_HDR_LEN)) begin
                opt_len <= OPT_CNT_W'(off_bytes - 6'(`TCP_HDR_LEN));
                phase   <= ph_opt;
              end else if (pld_len == 16'd0) begin
                phase <= ph_done;
              end else begin
                phase <= ph_pld;
              end
            end
          end
        end
        ph_opt: begin
          if (opt_act) begin
            opt_cnt <= opt_cnt + OPT_CNT_W'(1);
            if (opt_cnt == opt_len - OPT_CNT_W'(1)) begin
              phase <= (pld_len == 16'd0) ? ph_done : ph_pld;
            end
          end
        end
        ph_pld: begin
          if (pld_act) begin
            pld_cnt <= pld_cnt + 16'd1;
            if (pld_last) phase <= ph_done;
          end
        end
        ph_done: begin
          phase <= ph_idle;
        end
        ph_skip: begin
          if (in_strm.val && in_strm.eof) phase <= ph_idle;
        end
        default: begin
          phase <= ph_idle;
        end
      endcase
    end
  end

  // header bytes 1..19 are counted while in the header phase
  a_hdr_cnt_range: assert property (@(posedge clk) disable iff (fsm_rst)
    (phase == ph_hdr) |-> (hdr_cnt < HDR_CNT_W'(`TCP_HDR_LEN)));

endmodule

`default_nettype wire

//--- hdl/tcp_opt_parse.sv
`default_nettype none
`timescale 1ns/1ps
`include "tcp_rx_config.svh"

module tcp_opt_parse (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  net_stream_pkg::byte_strm_t byte_bus,
  input  logic                       opt_act,
  input  logic                       frame_done,
  output tcp_hdr_pkg::tcp_opt_t      opt
);

  import tcp_hdr_pkg::*;

  localparam int OPT_CNT_W = $clog2(`TCP_MAX_OPT_LEN + 1);

  typedef enum logic [1:0] {fld_kind, fld_len, fld_data} field_t;

  field_t               field;
  tcp_opt_kind_t        cur_kind;
  logic [OPT_CNT_W-1:0] data_len;
  logic [OPT_CNT_W-1:0] data_cnt;
  // seven older data bytes plus the current one give the 8-byte timestamp
  logic [6:0][7:0]      data_win;
  logic [7:0]           dat;

  assign dat = byte_bus.dat;

  always_ff @(posedge clk) begin
    if (fsm_rst || frame_done) begin
      field    <= fld_kind;
      data_cnt <= '0;
      opt      <= '0;
    end else if (opt_act) begin
      case (field)
        fld_kind: begin
          cur_kind <= tcp_opt_kind_t'(dat);
          data_cnt <= '0;
          // end and nop have no length byte
          if ((dat != opt_end) && (dat != opt_nop)) field <= fld_len;
        end
        fld_len: begin
          // length counts kind and length bytes too
          data_len <= OPT_CNT_W'(dat - 8'd2);
          if (cur_kind == opt_sack) begin
            opt.sack_pres <= 1'b1;
            case (dat)
              8'd10:   opt.sack_blocks <= 3'd1;
              8'd18:   opt.sack_blocks <= 3'd2;
              8'd26:   opt.sack_blocks <= 3'd3;
              8'd34:   opt.sack_blocks <= 3'd4;
              default: opt.sack_blocks <= 3'd0;
            endcase
          end
          if (dat <= 8'd2) begin
            field <= fld_kind;
            if (cur_kind == opt_sack_perm) opt.sack_perm <= 1'b1;
          end else begin
            field <= fld_data;
          end
        end
        fld_data: begin
          data_win <= {data_win[5:0], dat};
          data_cnt <= data_cnt + OPT_CNT_W'(1);
          if (data_cnt == data_len - OPT_CNT_W'(1)) begin
            field <= fld_kind;
            // unknown kinds and sack blocks are only skipped
            case (cur_kind)
              opt_mss: begin
                opt.mss_pres <= 1'b1;
                opt.mss      <= {data_win[0], dat};
              end
              opt_win: begin
                opt.win_pres  <= 1'b1;
                opt.win_scale <= dat;
              end
              opt_ts: begin
                opt.ts_pres              <= 1'b1;
                {opt.ts_val, opt.ts_echo} <= {data_win, dat};
              end
              default: begin
              end
            endcase
          end
        end
        default: begin
          field <= fld_kind;
        end
      endcase
    end
  end

  // an option never runs past the option area the decoder marked
  a_kind_outside_opts: assert property (@(posedge clk) disable iff (fsm_rst)
    !opt_act |-> (field == fld_kind));

endmodule

`default_nettype wire

//--- hdl/tcp_pld_out.sv
`default_nettype none
`timescale 1ns/1ps

module tcp_pld_out (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  net_stream_pkg::byte_strm_t byte_bus,
  input  logic                       pld_act,
  input  logic                       pld_first,
  input  logic                       pld_last,
  input  logic                       frame_done,
  input  tcp_hdr_pkg::tcp_hdr_t      hdr,
  input  net_stream_pkg::ipv4_meta_t ip_meta,
  input  logic [15:0]                pld_len,
  input  tcp_hdr_pkg::tcp_opt_t      opt,
  output net_stream_pkg::byte_strm_t tcp_strm,
  output tcp_hdr_pkg::tcp_meta_t     tcp_meta
);

  // one cycle after the done phase, the metadata is dropped
  logic done_q;

  always_ff @(posedge clk) begin
    tcp_strm.dat <= byte_bus.dat;
    if (fsm_rst) begin
      tcp_strm.val <= 1'b0;
      tcp_strm.sof <= 1'b0;
      tcp_strm.eof <= 1'b0;
      tcp_meta     <= '0;
      done_q       <= 1'b0;
    end else begin
      done_q       <= frame_done;
      tcp_strm.val <= pld_act;
      tcp_strm.sof <= pld_first;
      tcp_strm.eof <= pld_last;
      if (done_q) begin
        tcp_meta <= '0;
      end else if (!tcp_meta.val && (pld_first || frame_done)) begin
        // options are complete here, they always precede the payload
        tcp_meta.val     <= 1'b1;
        tcp_meta.ipv4    <= ip_meta;
        tcp_meta.hdr     <= hdr;
        tcp_meta.opt     <= opt;
        tcp_meta.pld_len <= pld_len;
      end
    end
  end

  // after the last byte the stream pauses while the metadata is still held
  a_eof_then_gap: assert property (@(posedge clk) disable iff (fsm_rst)
    tcp_strm.eof |-> tcp_strm.val ##1 (!tcp_strm.val && tcp_meta.val));

endmodule

`default_nettype wire

//--- hdl/tcp_rx.sv
`default_nettype none
`timescale 1ns/1ps

module tcp_rx (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  net_stream_pkg::byte_strm_t in_strm,
  input  net_stream_pkg::ipv4_meta_t in_meta,
  output net_stream_pkg::byte_strm_t tcp_strm,
  output tcp_hdr_pkg::tcp_meta_t     tcp_meta
);

  import net_stream_pkg::*;
  import tcp_hdr_pkg::*;

  byte_strm_t  byte_bus;
  logic        opt_act;
  logic        pld_act;
  logic        pld_first;
  logic        pld_last;
  logic        frame_done;
  tcp_hdr_t    hdr;
  ipv4_meta_t  ip_meta;
  logic [15:0] pld_len;
  tcp_opt_t    opt;

  tcp_hdr_decode u_decode (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .in_strm    (in_strm),
    .in_meta    (in_meta),
    .byte_bus   (byte_bus),
    .opt_act    (opt_act),
    .pld_act    (pld_act),
    .pld_first  (pld_first),
    .pld_last   (pld_last),
    .frame_done (frame_done),
    .hdr        (hdr),
    .ip_meta    (ip_meta),
    .pld_len    (pld_len)
  );

  tcp_opt_parse u_opt_parse (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .byte_bus   (byte_bus),
    .opt_act    (opt_act),
    .frame_done (frame_done),
    .opt        (opt)
  );

  tcp_pld_out u_pld_out (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .byte_bus   (byte_bus),
    .pld_act    (pld_act),
    .pld_first  (pld_first),
    .pld_last   (pld_last),
    .frame_done (frame_done),
    .hdr        (hdr),
    .ip_meta    (ip_meta),
    .pld_len    (pld_len),
    .opt        (opt),
    .tcp_strm   (tcp_strm),
    .tcp_meta   (tcp_meta)
  );

endmodule

`default_nettype wire

//--- test/tb_tcp_rx.sv
`default_nettype none
`timescale 1ns/1ps
`include "tcp_rx_config.svh"

module tb_tcp_rx;

  import net_stream_pkg::*;
  import tcp_hdr_pkg::*;

  localparam int          TIMEOUT = 3000;
  localparam logic [31:0] SEED    = 32'h4390224c;

  logic       clk;
  logic       fsm_rst;
  byte_strm_t in_strm;
  ipv4_meta_t in_meta;
  byte_strm_t tcp_strm;
  tcp_meta_t  tcp_meta;

  logic [31:0] lfsr;
  string       test_name;
  logic [7:0]  opt_bytes[$];
  logic [7:0]  pld[$];
  tcp_opt_t    exp_opt;
  byte_strm_t  exp_bytes[$];
  byte_strm_t  out_q[$];
  tcp_meta_t   exp_meta[$];
  tcp_meta_t   meta_q[$];
  logic        meta_sof_q[$];
  int          strm_val_cnt;
  int          meta_hi_cnt;
  logic        meta_busy;

  tcp_rx dut0 (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .in_strm  (in_strm),
    .in_meta  (in_meta),
    .tcp_strm (tcp_strm),
    .tcp_meta (tcp_meta)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // outputs are sampled mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (tcp_strm.val) begin
      out_q.push_back(tcp_strm);
      strm_val_cnt++;
    end
    if (tcp_meta.val) begin
      meta_hi_cnt++;
      if (!meta_busy) begin
        meta_q.push_back(tcp_meta);
        meta_sof_q.push_back(tcp_strm.val && tcp_strm.sof);
      end
    end else if (!fsm_rst && (tcp_meta !== '0)) begin
      fail_run("tcp_meta fields are not cleared while tcp_meta val is low");
    end
    meta_busy = tcp_meta.val;
  end

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    int         i;
    v = '0;
    for (i = 0; i < n; i++) v = {v[6:0], lfsr_bit()};
    return v;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on error");
  endtask

  task automatic check(input string what, input logic [159:0] exp, input logic [159:0] act);
    if (exp !== act) begin
      fail_run($sformatf("** Error [%s] %s: expected %0h, actual %0h",
                         test_name, what, exp, act));
    end
  endtask

  function automatic tcp_hdr_t make_hdr(input logic [31:0] seq, input logic [11:0] flags,
                                        input int n_opt);
    tcp_hdr_t h;
    h.src_port = 16'hc350 ^ seq[15:0];
    h.dst_port = 16'h0050;
    h.seq      = seq;
    h.ack      = ~seq;
    h.offset   = 4'(5 + n_opt / 4);
    h.flags    = flags;
    h.window   = 16'hfaf0;
    h.checksum = seq[31:16];
    h.urg_ptr  = 16'h0000;
    return h;
  endfunction

  // header, options and payload go out gap-free, then one idle cycle
  task automatic send_frame(input logic [7:0] proto, input tcp_hdr_t h);
    ipv4_meta_t   m;
    tcp_meta_t    em;
    logic [159:0] hbits;
    logic [7:0]   frm[$];
    int           i;
    int           n;
    hbits = h;
    for (i = 0; i < `TCP_HDR_LEN; i++) frm.push_back(hbits[159 - 8 * i -: 8]);
    for (i = 0; i < opt_bytes.size(); i++) frm.push_back(opt_bytes[i]);
    for (i = 0; i < pld.size(); i++) frm.push_back(pld[i]);
    n         = frm.size();
    m.src_ip  = {16'hc0a8, h.seq[15:0]};
    m.dst_ip  = 32'h0a000002;
    m.proto   = proto;
    m.pld_len = 16'(n);
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      in_strm.dat = frm[i];
      in_strm.val = 1'b1;
      in_strm.sof = (i == 0);
      in_strm.eof = (i == n - 1);
      in_meta     = (i == 0) ? m : '0;
    end
    @(posedge clk);
    #1;
    in_strm = '0;
    in_meta = '0;
    if (proto == `TCP_PROTO) begin
      for (i = 0; i < pld.size(); i++) begin
        exp_bytes.push_back({pld[i], 1'b1, i == 0, i == pld.size() - 1});
      end
      em.val     = 1'b1;
      em.ipv4    = m;
      em.hdr     = h;
      em.opt     = exp_opt;
      // payload length is the ipv4 length minus the data offset in bytes
      em.pld_len = m.pld_len - 16'(h.offset) * 16'd4;
      exp_meta.push_back(em);
    end
  endtask

  function automatic logic outputs_pending();
    return (out_q.size() < exp_bytes.size()) || (meta_q.size() < exp_meta.size()) || meta_busy;
  endfunction

  task automatic expect_outputs();
    int         cyc;
    byte_strm_t eb;
    byte_strm_t gb;
    tcp_meta_t  em;
    tcp_meta_t  gm;
    logic       gs;
    cyc = 0;
    while (outputs_pending() && (cyc < TIMEOUT)) begin
      @(posedge clk);
      cyc++;
    end
    if (outputs_pending()) begin
      fail_run($sformatf("timeout in %s: payload or tcp_meta of the frames never completed",
                         test_name));
    end
    check("payload byte count", exp_bytes.size(), out_q.size());
    check("metadata count", exp_meta.size(), meta_q.size());
    while (exp_bytes.size() > 0) begin
      eb = exp_bytes.pop_front();
      gb = out_q.pop_front();
      check("payload byte with sof/eof", eb, gb);
    end
    while (exp_meta.size() > 0) begin
      em = exp_meta.pop_front();
      gm = meta_q.pop_front();
      gs = meta_sof_q.pop_front();
      // with a payload, tcp_meta val rises together with the output sof
      check("tcp_meta val rise with first byte", em.pld_len != 16'd0, gs);
      check("ipv4 metadata", em.ipv4, gm.ipv4);
      check("tcp header", em.hdr, gm.hdr);
      check("options", em.opt, gm.opt);
      check("payload length", em.pld_len, gm.pld_len);
    end
  endtask

  // mss 1460, nop, window scale 7, sack permitted, timestamp, 20 bytes
  task automatic load_syn_opts();
    opt_bytes = '{opt_mss, 8'd4, 8'h05, 8'hb4, opt_nop, opt_win, 8'd3, 8'd7,
                  opt_sack_perm, 8'd2, opt_ts, 8'd10, 8'h11, 8'h22, 8'h33, 8'h44,
                  8'h55, 8'h66, 8'h77, 8'h88};
    exp_opt           = '0;
    exp_opt.mss_pres  = 1'b1;
    exp_opt.mss       = 16'd1460;
    exp_opt.win_pres  = 1'b1;
    exp_opt.win_scale = 8'd7;
    exp_opt.sack_perm = 1'b1;
    exp_opt.ts_pres   = 1'b1;
    exp_opt.ts_val    = 32'h11223344;
    exp_opt.ts_echo   = 32'h55667788;
  endtask

  task automatic test_plain();
    int i;
    test_name = "plain";
    opt_bytes.delete();
    pld.delete();
    for (i = 0; i < 12; i++) pld.push_back(8'ha0 + 8'(i));
    exp_opt = '0;
    send_frame(`TCP_PROTO, make_hdr(32'h10000001, 12'h018, 0));
    expect_outputs();
  endtask

  task automatic test_options();
    int i;
    test_name = "options";
    load_syn_opts();
    pld.delete();
    for (i = 0; i < 8; i++) pld.push_back(8'h5a ^ 8'(i));
    send_frame(`TCP_PROTO, make_hdr(32'h20000002, 12'h018, opt_bytes.size()));
    expect_outputs();
  endtask

  task automatic test_syn_zero();
    int s0;
    int m0;
    test_name = "syn_zero_payload";
    load_syn_opts();
    pld.delete();
    s0 = strm_val_cnt;
    m0 = meta_hi_cnt;
    send_frame(`TCP_PROTO, make_hdr(32'h30000003, 12'h002, opt_bytes.size()));
    expect_outputs();
    check("stream beats", 0, strm_val_cnt - s0);
    check("tcp_meta val cycles", 1, meta_hi_cnt - m0);
  endtask

  task automatic test_non_tcp();
    int i;
    int s0;
    int m0;
    test_name = "non_tcp";
    opt_bytes.delete();
    pld.delete();
    exp_opt = '0;
    for (i = 0; i < 10; i++) pld.push_back(8'(i * 3));
    s0 = strm_val_cnt;
    m0 = meta_hi_cnt;
    send_frame(8'd17, make_hdr(32'h40000004, 12'h018, 0));
    // a tcp payload would show one clock after its input byte
    repeat (4) @(posedge clk);
    check("stream beats for udp", 0, strm_val_cnt - s0);
    check("tcp_meta val cycles for udp", 0, meta_hi_cnt - m0);
    pld.delete();
    for (i = 0; i < 5; i++) pld.push_back(8'hc0 + 8'(i));
    send_frame(`TCP_PROTO, make_hdr(32'h40000005, 12'h010, 0));
    expect_outputs();
  endtask

  task automatic test_sack_skip();
    int i;
    test_name = "sack_skip";
    opt_bytes = '{opt_sack, 8'd18};
    for (i = 0; i < 16; i++) opt_bytes.push_back(8'h80 + 8'(i));
    // kind 30 is unknown and only skipped by its length
    opt_bytes = {opt_bytes, 8'd30, 8'd4, 8'hde, 8'had, opt_mss, 8'd4, 8'h02, 8'h18,
                 opt_nop, opt_nop};
    exp_opt             = '0;
    exp_opt.sack_pres   = 1'b1;
    exp_opt.sack_blocks = 3'd2;
    exp_opt.mss_pres    = 1'b1;
    exp_opt.mss         = 16'h0218;
    pld = '{8'h01, 8'h02, 8'h03, 8'h04};
    send_frame(`TCP_PROTO, make_hdr(32'h50000006, 12'h010, opt_bytes.size()));
    expect_outputs();
  endtask

  task automatic test_random();
    int f;
    int i;
    int n;
    test_name = "random_back_to_back";
    opt_bytes.delete();
    exp_opt = '0;
    for (f = 0; f < 3; f++) begin
      pld.delete();
      n = 1 + int'(rand_bits(6));
      for (i = 0; i < n; i++) pld.push_back(rand_bits(8));
      send_frame(`TCP_PROTO, make_hdr({24'h600000, 8'(f)}, 12'h018, 0));
    end
    expect_outputs();
  endtask

  initial begin
    fsm_rst      = 1'b1;
    in_strm      = '0;
    in_meta      = '0;
    lfsr         = SEED;
    strm_val_cnt = 0;
    meta_hi_cnt  = 0;
    meta_busy    = 1'b0;
    test_name    = "reset";
    repeat (10) @(posedge clk);
    #1;
    fsm_rst = 1'b0;
    check("tcp_strm val after reset", 0, tcp_strm.val);
    check("tcp_strm sof after reset", 0, tcp_strm.sof);
    check("tcp_strm eof after reset", 0, tcp_strm.eof);
    check("tcp_meta val after reset", 0, tcp_meta.val);
    test_plain();
    test_options();
    test_syn_zero();
    test_non_tcp();
    test_sack_skip();
    test_random();
    repeat (4) @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tcp_rx.f
+incdir+hdl
hdl/net_stream_pkg.sv
hdl/tcp_hdr_pkg.sv
hdl/tcp_hdr_decode.sv
hdl/tcp_opt_parse.sv
hdl/tcp_pld_out.sv
hdl/tcp_rx.sv
test/tb_tcp_rx.sv
